/* Makefile */
VERILATOR ?= verilator
TOP       ?= video_ctrl_tb
SEED      ?= 0
LOG       ?= sim.log
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -Wno-fatal --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/video_ctrl_tb.sv */
// two rows wait for whole frames, so a run covers about 300k clocks; no reads of the ports exist
`timescale 1ns/100ps
`default_nettype none

module video_ctrl_tb
    import video_bus_pkg::*;
    import video_cfg_pkg::*;
();

    typedef enum int {W_NONE, W_LINE, W_FRAME} wait_t;
    typedef enum int {
        F_BORDER, F_VPAGE, F_VCONF, F_PALSEL, F_HINT, F_TSCONF, F_TMPAGE, F_T0GPAGE,
        F_T1GPAGE, F_SGPAGE, F_GX, F_GY, F_T0X, F_T0Y, F_T1X, F_T1Y, F_VINT
    } field_t;

    localparam int NRAND = 48;

    logic          clk = 1'b0;
    logic          rst_n;
    cpu_wr_t       cpu;
    video_params_t params;
    raster_pos_t   raster;
    logic          int_n;

    // stimulus table, one entry per row in each column
    string      t_name[$];
    bit         t_legacy[$];
    logic [7:0] t_port[$];
    logic [7:0] t_data[$];
    wait_t      t_wait[$];
    field_t     t_field[$];
    logic [8:0] t_exp[$];

    // reference model state
    video_params_t model_params;
    video_params_t model_shadow;
    logic [3:0]    model_step;
    int            model_h;
    int            model_v;
    int            model_int_left;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 0;
    int low_run = 0;
    int pulses = 0;
    int seed;

    video_ctrl_top u_video_ctrl_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .cpu    (cpu),
        .params (params),
        .raster (raster),
        .int_n  (int_n)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit)
        begin
            $display("timeout after %0d clock cycles, the test sequence did not finish", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [8:0] field_of(input video_params_t p, input field_t f);
        case (f)
            F_BORDER:  return {1'b0, p.border};
            F_VPAGE:   return {1'b0, p.vpage};
            F_VCONF:   return {1'b0, p.vconf};
            F_PALSEL:  return {1'b0, p.palsel};
            F_HINT:    return {1'b0, p.hint_beg};
            F_TSCONF:  return {1'b0, p.tsconf};
            F_TMPAGE:  return {1'b0, p.tmpage};
            F_T0GPAGE: return {1'b0, p.t0gpage};
            F_T1GPAGE: return {1'b0, p.t1gpage};
            F_SGPAGE:  return {1'b0, p.sgpage};
            F_GX:      return p.gx_offs;
            F_GY:      return p.gy_offs;
            F_T0X:     return p.t0x_offs;
            F_T0Y:     return p.t0y_offs;
            F_T1X:     return p.t1x_offs;
            F_T1Y:     return p.t1y_offs;
            default:   return p.vint_beg;
        endcase
    endfunction

    function automatic logic [8:0] next_vint(input logic [8:0] v, input logic [3:0] s);
        logic [8:0] n;
        begin
            n = v + {5'd0, s};
            // lines 320 to 383 fold back onto 0 to 63
            if (n >= 9'd320 && n <= 9'd383)
                n = n - 9'd320;
            return n;
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [151:0] expv,
                                   input logic [151:0] actv);
        begin
            errors = errors + 1;
            $display("** Error %s: expected %0h, actual %0h", name, expv, actv);
        end
    endtask

    // one cpu write as the register rules describe it; staged fields go to the shadow
    task automatic model_write(input cpu_wr_t w, inout video_params_t nxt);
        begin
            if (w.legacy)
            begin
                case (w.addr)
                    PORT_ZBORDER: nxt.border = {5'b11110, w.data[2:0]};
                    PORT_ZVPAGE:
                    begin
                        nxt.vpage          = {6'b000001, w.data[3], 1'b1};
                        model_shadow.vpage = nxt.vpage;
                    end
                    default: ;
                endcase
            end
            else
            begin
                case (w.addr)
                    PORT_BORDER:    nxt.border = w.data;
                    PORT_GY_OFFSL:  nxt.gy_offs[7:0] = w.data;
                    PORT_GY_OFFSH:  nxt.gy_offs[8] = w.data[0];
                    PORT_T0Y_OFFSL: nxt.t0y_offs[7:0] = w.data;
                    PORT_T0Y_OFFSH: nxt.t0y_offs[8] = w.data[0];
                    PORT_T1Y_OFFSL: nxt.t1y_offs[7:0] = w.data;
                    PORT_T1Y_OFFSH: nxt.t1y_offs[8] = w.data[0];
                    PORT_TSCONF:    nxt.tsconf = w.data;
                    PORT_TMPAGE:    nxt.tmpage = w.data;
                    PORT_SGPAGE:    nxt.sgpage = w.data;
                    PORT_HINT_BEG:  nxt.hint_beg = w.data;
                    PORT_VINT_BEGL: nxt.vint_beg = {model_params.vint_beg[8], w.data};
                    PORT_VINT_BEGH:
                    begin
                        nxt.vint_beg = {w.data[0], model_params.vint_beg[7:0]};
                        model_step   = w.data[7:4];
                    end
                    PORT_VPAGE:     model_shadow.vpage = w.data;
                    PORT_VCONF:     model_shadow.vconf = w.data;
                    PORT_PALSEL:    model_shadow.palsel = w.data;
                    PORT_T0GPAGE:   model_shadow.t0gpage = w.data;
                    PORT_T1GPAGE:   model_shadow.t1gpage = w.data;
                    PORT_GX_OFFSL:  model_shadow.gx_offs[7:0] = w.data;
                    PORT_GX_OFFSH:  model_shadow.gx_offs[8] = w.data[0];
                    PORT_T0X_OFFSL: model_shadow.t0x_offs[7:0] = w.data;
                    PORT_T0X_OFFSH: model_shadow.t0x_offs[8] = w.data[0];
                    PORT_T1X_OFFSL: model_shadow.t1x_offs[7:0] = w.data;
                    PORT_T1X_OFFSH: model_shadow.t1x_offs[8] = w.data[0];
                    default: ;
                endcase
            end
        end
    endtask

    task automatic check_cycle;
        raster_pos_t exp_r;
        begin
            exp_r.hcount      = 9'(model_h);
            exp_r.vcount      = 9'(model_v);
            exp_r.line_start  = (model_h == 0);
            exp_r.frame_start = (model_h == 0) && (model_v == 0);
            checks = checks + 1;
            if (raster !== exp_r)
                report_mismatch("raster", exp_r, raster);
            if (int_n !== (model_int_left == 0))
                report_mismatch("int_n", model_int_left == 0, int_n);
            // pulse length measured on int_n alone
            if (int_n === 1'b0)
                low_run = low_run + 1;
            else
            begin
                if (low_run != 0 && low_run != INT_LEN)
                begin
                    errors = errors + 1;
                    $display("frame interrupt stayed low for %0d clocks instead of %0d",
                             low_run, INT_LEN);
                end
                if (low_run != 0)
                    pulses = pulses + 1;
                low_run = 0;
            end
        end
    endtask

    // advance the model over the coming rising edge, then sample at the falling edge
    task automatic clock_step;
        video_params_t nxt;
        logic          ls;
        logic          fs;
        begin
            ls  = (model_h == 0);
            fs  = ls && (model_v == 0);
            nxt = model_params;
            if (model_v == int'(model_params.vint_beg) &&
                model_h == 2 * int'(model_params.hint_beg))
                model_int_left = INT_LEN;
            else if (model_int_left > 0)
                model_int_left = model_int_left - 1;
            if (ls)
            begin
                nxt.vpage    = model_shadow.vpage;
                nxt.vconf    = model_shadow.vconf;
                nxt.palsel   = model_shadow.palsel;
                nxt.t0gpage  = model_shadow.t0gpage;
                nxt.t1gpage  = model_shadow.t1gpage;
                nxt.gx_offs  = model_shadow.gx_offs;
                nxt.t0x_offs = model_shadow.t0x_offs;
                nxt.t1x_offs = model_shadow.t1x_offs;
            end
            if (fs)
                nxt.vint_beg = next_vint(model_params.vint_beg, model_step);
            if (cpu.wr)
                model_write(cpu, nxt);
            model_params = nxt;
            if (model_h == H_TOTAL - 1)
            begin
                model_h = 0;
                model_v = (model_v == V_TOTAL - 1) ? 0 : model_v + 1;
            end
            else
                model_h = model_h + 1;
            @(posedge clk);
            @(negedge clk);
            check_cycle();
        end
    endtask

    task automatic apply_write(input bit legacy, input logic [7:0] port, input logic [7:0] d);
        begin
            cpu = '{wr: 1'b1, legacy: legacy, addr: port, data: d};
            clock_step();
            cpu = '0;
        end
    endtask

    task automatic add_row(input string name, input bit legacy, input logic [7:0] port,
                           input logic [7:0] data, input wait_t w, input field_t f,
                           input logic [8:0] expv);
        begin
            t_name.push_back(name);
            t_legacy.push_back(legacy);
            t_port.push_back(port);
            t_data.push_back(data);
            t_wait.push_back(w);
            t_field.push_back(f);
            t_exp.push_back(expv);
        end
    endtask

    task automatic build_table;
        begin
            add_row("border",     1'b0, PORT_BORDER,    8'hA5, W_NONE,  F_BORDER,  9'h0A5);
            add_row("gy_offs_l",  1'b0, PORT_GY_OFFSL,  8'h3C, W_NONE,  F_GY,      9'h03C);
            add_row("gy_offs_h",  1'b0, PORT_GY_OFFSH,  8'h01, W_NONE,  F_GY,      9'h13C);
            add_row("t0y_offs_l", 1'b0, PORT_T0Y_OFFSL, 8'h77, W_NONE,  F_T0Y,     9'h077);
            add_row("t0y_offs_h", 1'b0, PORT_T0Y_OFFSH, 8'h01, W_NONE,  F_T0Y,     9'h177);
            add_row("t1y_offs_l", 1'b0, PORT_T1Y_OFFSL, 8'h9A, W_NONE,  F_T1Y,     9'h09A);
            add_row("tsconf",     1'b0, PORT_TSCONF,    8'hC3, W_NONE,  F_TSCONF,  9'h0C3);
            add_row("tmpage",     1'b0, PORT_TMPAGE,    8'h21, W_NONE,  F_TMPAGE,  9'h021);
            add_row("sgpage",     1'b0, PORT_SGPAGE,    8'h42, W_NONE,  F_SGPAGE,  9'h042);
            // column 96 lies past the end of the pulse fired at column 4
            add_row("hint_beg",   1'b0, PORT_HINT_BEG,  8'h30, W_NONE,  F_HINT,    9'h030);
            // staged fields, published at the next line start
            add_row("vpage",      1'b0, PORT_VPAGE,     8'h20, W_LINE,  F_VPAGE,   9'h020);
            add_row("vconf",      1'b0, PORT_VCONF,     8'h83, W_LINE,  F_VCONF,   9'h083);
            add_row("gx_offs_l",  1'b0, PORT_GX_OFFSL,  8'h55, W_LINE,  F_GX,      9'h055);
            add_row("gx_offs_h",  1'b0, PORT_GX_OFFSH,  8'h01, W_LINE,  F_GX,      9'h155);
            add_row("palsel",     1'b0, PORT_PALSEL,    8'h3A, W_LINE,  F_PALSEL,  9'h03A);
            add_row("t0x_offs_l", 1'b0, PORT_T0X_OFFSL, 8'h12, W_LINE,  F_T0X,     9'h012);
            add_row("t1x_offs_h", 1'b0, PORT_T1X_OFFSH, 8'h01, W_LINE,  F_T1X,     9'h100);
            add_row("t0gpage",    1'b0, PORT_T0GPAGE,   8'h66, W_LINE,  F_T0GPAGE, 9'h066);
            add_row("t1gpage",    1'b0, PORT_T1GPAGE,   8'h99, W_LINE,  F_T1GPAGE, 9'h099);
            add_row("zborder",    1'b1, PORT_ZBORDER,   8'h05, W_NONE,  F_BORDER,  9'h0F5);
            add_row("zvpage_d3",  1'b1, PORT_ZVPAGE,    8'h08, W_NONE,  F_VPAGE,   9'h007);
            add_row("zvpage",     1'b1, PORT_ZVPAGE,    8'h00, W_NONE,  F_VPAGE,   9'h005);
            // line 318 with step 4 wraps to 2, then 6
            add_row("vint_beg_l", 1'b0, PORT_VINT_BEGL, 8'h3E, W_NONE,  F_VINT,    9'h03E);
            add_row("vint_beg_h", 1'b0, PORT_VINT_BEGH, 8'h41, W_NONE,  F_VINT,    9'h13E);
            add_row("vint_wrap",  1'b0, 8'hFF,          8'h00, W_FRAME, F_VINT,    9'h002);
            add_row("vint_step",  1'b0, 8'hFF,          8'h00, W_FRAME, F_VINT,    9'h006);
        end
    endtask

    task automatic run_row(input int i);
        logic [8:0] act;
        begin
            apply_write(t_legacy[i], t_port[i], t_data[i]);
            if (t_wait[i] == W_LINE)
            begin
                // staged value must not show before the line start
                checks = checks + 1;
                if (field_of(params, t_field[i]) !== field_of(model_params, t_field[i]))
                    report_mismatch({t_name[i], "_hold"}, field_of(model_params, t_field[i]),
                                    field_of(params, t_field[i]));
                while (raster.line_start !== 1'b1)
                    clock_step();
                clock_step();
            end
            else if (t_wait[i] == W_FRAME)
            begin
                while (raster.frame_start !== 1'b1)
                    clock_step();
                clock_step();
            end
            act    = field_of(params, t_field[i]);
            checks = checks + 2;
            if (act !== t_exp[i])
                report_mismatch(t_name[i], t_exp[i], act);
            if (params !== model_params)
                report_mismatch({t_name[i], "_model"}, model_params, params);
        end
    endtask

    task automatic random_pass;
        logic [8:0] ports [26];
        int         idx;
        logic [7:0] d;
        begin
            ports = '{{1'b0, PORT_VCONF}, {1'b0, PORT_VPAGE}, {1'b0, PORT_GX_OFFSL},
                      {1'b0, PORT_GX_OFFSH}, {1'b0, PORT_GY_OFFSL}, {1'b0, PORT_GY_OFFSH},
                      {1'b0, PORT_TSCONF}, {1'b0, PORT_PALSEL}, {1'b0, PORT_BORDER},
                      {1'b0, PORT_TMPAGE}, {1'b0, PORT_T0GPAGE}, {1'b0, PORT_T1GPAGE},
                      {1'b0, PORT_SGPAGE}, {1'b0, PORT_HINT_BEG}, {1'b0, PORT_VINT_BEGL},
                      {1'b0, PORT_VINT_BEGH}, {1'b0, PORT_T0X_OFFSL}, {1'b0, PORT_T0X_OFFSH},
                      {1'b0, PORT_T0Y_OFFSL}, {1'b0, PORT_T0Y_OFFSH}, {1'b0, PORT_T1X_OFFSL},
                      {1'b0, PORT_T1X_OFFSH}, {1'b0, PORT_T1Y_OFFSL}, {1'b0, PORT_T1Y_OFFSH},
                      {1'b1, PORT_ZBORDER}, {1'b1, PORT_ZVPAGE}};
            for (int n = 0; n < NRAND; n++)
            begin
                idx = $unsigned($random(seed)) % 26;
                d   = 8'($random(seed));
                apply_write(ports[idx][8], ports[idx][7:0], d);
                checks = checks + 1;
                if (params !== model_params)
                    report_mismatch($sformatf("random_%0d", n), model_params, params);
            end
            // staged random writes reach params at the next line start
            while (raster.line_start !== 1'b1)
                clock_step();
            clock_step();
            checks = checks + 1;
            if (params !== model_params)
                report_mismatch("random_staged", model_params, params);
        end
    endtask

    initial
    begin
        cpu   = '0;
        rst_n = 1'b0;
        seed  = 32'h5fc07954;
        build_table();
        limit = 3 * H_TOTAL * V_TOTAL + 1000 * (t_name.size() + NRAND);

        model_params          = '0;
        model_params.vpage    = 8'h05;
        model_params.palsel   = 8'h0F;
        model_params.hint_beg = 8'd2;
        model_shadow          = model_params;
        model_step            = 4'd0;
        model_h               = 0;
        model_v               = 0;
        model_int_left        = 0;

        repeat (4) @(negedge clk);
        rst_n  = 1'b1;
        checks = checks + 2;
        if (params !== model_params)
            report_mismatch("reset_params", model_params, params);
        if (int_n !== 1'b1)
            report_mismatch("reset_int_n", 1'b1, int_n);

        for (int i = 0; i < t_name.size(); i++)
            run_row(i);
        random_pass();

        // line 0 fires at columns 4 and 96, then line 318 and line 2 once each
        if (pulses < 4)
        begin
            errors = errors + 1;
            $display("frame interrupt fired %0d times, at least 4 were expected", pulses);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
rtl/video_bus_pkg.sv
rtl/video_cfg_pkg.sv
rtl/video_port_decode.sv
rtl/video_ports.sv
rtl/raster_timer.sv
rtl/video_int_gen.sv
rtl/video_ctrl_top.sv
bench/video_ctrl_tb.sv

/* rtl/raster_timer.sv */
// free-running counters only; no sync outputs and no blanking, pulses are decoded from the counts
`timescale 1ns/100ps
`default_nettype none

module raster_timer
    import video_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    output raster_pos_t raster
);

    logic [HCNT_W-1:0] hcnt;
    logic [VCNT_W-1:0] vcnt;
    logic              h_last;
    logic              v_last;

    assign h_last = (hcnt == HCNT_W'(H_TOTAL - 1));
    assign v_last = (vcnt == VCNT_W'(V_TOTAL - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hcnt <= '0;
            vcnt <= '0;
        end
        else if (h_last)
        begin
            hcnt <= '0;
            // line counter steps on the horizontal wrap
            if (v_last)
                vcnt <= '0;
            else
                vcnt <= vcnt + 1'b1;
        end
        else
        begin
            hcnt <= hcnt + 1'b1;
        end
    end

    always_comb
    begin
        raster.hcount      = hcnt;
        raster.vcount      = vcnt;
        raster.line_start  = (hcnt == '0);
        raster.frame_start = (hcnt == '0) && (vcnt == '0);
    end

endmodule

`default_nettype wire

/* rtl/video_bus_pkg.sv */
// CPU-side I/O write format, port numbers and register write strobes; reads are not modelled
`default_nettype none

package video_bus_pkg;

    // one CPU I/O write, valid while wr is high
    typedef struct packed {
        logic       wr;
        logic       legacy;
        logic [7:0] addr;
        logic [7:0] data;
    } cpu_wr_t;

    // extended register space
    localparam logic [7:0] PORT_VCONF     = 8'h00;
    localparam logic [7:0] PORT_VPAGE     = 8'h01;
    localparam logic [7:0] PORT_GX_OFFSL  = 8'h02;
    localparam logic [7:0] PORT_GX_OFFSH  = 8'h03;
    localparam logic [7:0] PORT_GY_OFFSL  = 8'h04;
    localparam logic [7:0] PORT_GY_OFFSH  = 8'h05;
    localparam logic [7:0] PORT_TSCONF    = 8'h06;
    localparam logic [7:0] PORT_PALSEL    = 8'h07;
    localparam logic [7:0] PORT_BORDER    = 8'h0F;
    localparam logic [7:0] PORT_TMPAGE    = 8'h16;
    localparam logic [7:0] PORT_T0GPAGE   = 8'h17;
    localparam logic [7:0] PORT_T1GPAGE   = 8'h18;
    localparam logic [7:0] PORT_SGPAGE    = 8'h19;
    localparam logic [7:0] PORT_HINT_BEG  = 8'h22;
    localparam logic [7:0] PORT_VINT_BEGL = 8'h23;
    localparam logic [7:0] PORT_VINT_BEGH = 8'h24;

    // tile layer scroll offsets
    localparam logic [7:0] PORT_T0X_OFFSL = 8'h40;
    localparam logic [7:0] PORT_T0X_OFFSH = 8'h41;
    localparam logic [7:0] PORT_T0Y_OFFSL = 8'h42;
    localparam logic [7:0] PORT_T0Y_OFFSH = 8'h43;
    localparam logic [7:0] PORT_T1X_OFFSL = 8'h44;
    localparam logic [7:0] PORT_T1X_OFFSH = 8'h45;
    localparam logic [7:0] PORT_T1Y_OFFSL = 8'h46;
    localparam logic [7:0] PORT_T1Y_OFFSH = 8'h47;

    // legacy spectrum ports
    localparam logic [7:0] PORT_ZBORDER   = 8'hFE;
    localparam logic [7:0] PORT_ZVPAGE    = 8'hFD;

    // one strobe per register or register half
    typedef struct packed {
        logic zborder;
        logic border;
        logic zvpage;
        logic vpage;
        logic vconf;
        logic gx_offsl;
        logic gx_offsh;
        logic gy_offsl;
        logic gy_offsh;
        logic t0x_offsl;
        logic t0x_offsh;
        logic t0y_offsl;
        logic t0y_offsh;
        logic t1x_offsl;
        logic t1x_offsh;
        logic t1y_offsl;
        logic t1y_offsh;
        logic tsconf;
        logic palsel;
        logic tmpage;
        logic t0gpage;
        logic t1gpage;
        logic sgpage;
        logic hint_beg;
        logic vint_begl;
        logic vint_begh;
    } vport_wr_t;

endpackage

`default_nettype wire

/* rtl/video_cfg_pkg.sv */
// raster geometry is fixed at 448 x 320; counters are 9 bits, so larger sizes need wider fields
`default_nettype none

package video_cfg_pkg;

    // raster geometry
    localparam int HCNT_W  = 9;
    localparam int VCNT_W  = 9;
    localparam int H_TOTAL = 448;
    localparam int V_TOTAL = 320;

    // frame interrupt length in clocks
    localparam int INT_LEN   = 32;
    localparam int INT_CNT_W = $clog2(INT_LEN + 1);

    // reset values of the non-zero registers
    localparam logic [7:0] VPAGE_RST    = 8'h05;
    localparam logic [7:0] VCONF_RST    = 8'h00;
    localparam logic [7:0] PALSEL_RST   = 8'h0F;
    localparam logic [7:0] HINT_BEG_RST = 8'd2;

    // legacy write formats
    localparam logic [4:0] ZBORDER_HI = 5'b11110;
    // page code is 000001_d3_1, d3 is ORed into bit 1
    localparam logic [7:0] ZVPAGE_FMT = 8'b0000_0101;

    // line numbers 320..383 fold back to 0..63
    localparam logic [2:0] VINT_WRAP_HI = 3'b101;

    typedef struct packed {
        logic [7:0] border;
        logic [7:0] vpage;
        logic [7:0] vconf;
        logic [7:0] palsel;
        logic [7:0] hint_beg;
        logic [7:0] tsconf;
        logic [7:0] tmpage;
        logic [7:0] t0gpage;
        logic [7:0] t1gpage;
        logic [7:0] sgpage;
        logic [8:0] gx_offs;
        logic [8:0] gy_offs;
        logic [8:0] t0x_offs;
        logic [8:0] t0y_offs;
        logic [8:0] t1x_offs;
        logic [8:0] t1y_offs;
        logic [8:0] vint_beg;
    } video_params_t;

    localparam video_params_t PARAMS_RST = '{
        border:   8'h00,
        vpage:    VPAGE_RST,
        vconf:    VCONF_RST,
        palsel:   PALSEL_RST,
        hint_beg: HINT_BEG_RST,
        tsconf:   8'h00,
        tmpage:   8'h00,
        t0gpage:  8'h00,
        t1gpage:  8'h00,
        sgpage:   8'h00,
        gx_offs:  9'd0,
        gy_offs:  9'd0,
        t0x_offs: 9'd0,
        t0y_offs: 9'd0,
        t1x_offs: 9'd0,
        t1y_offs: 9'd0,
        vint_beg: 9'd0
    };

    typedef struct packed {
        logic [HCNT_W-1:0] hcount;
        logic [VCNT_W-1:0] vcount;
        logic              line_start;
        logic              frame_start;
    } raster_pos_t;

endpackage

`default_nettype wire

/* rtl/video_ctrl_top.sv */
// write-only control path; the CPU sees no wait states and no read-back of any register
`timescale 1ns/100ps
`default_nettype none

module video_ctrl_top
    import video_bus_pkg::*;
    import video_cfg_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  cpu_wr_t       cpu,
    output video_params_t params,
    output raster_pos_t   raster,
    output logic          int_n
);

    vport_wr_t  strobes;
    logic [7:0] wr_data;

    video_port_decode u_decode (
        .cpu     (cpu),
        .strobes (strobes),
        .data    (wr_data)
    );

    video_ports u_ports (
        .clk         (clk),
        .rst_n       (rst_n),
        .strobes     (strobes),
        .data        (wr_data),
        .line_start  (raster.line_start),
        .frame_start (raster.frame_start),
        .params      (params)
    );

    raster_timer u_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .raster (raster)
    );

    // interrupt position comes straight from the published parameters
    video_int_gen u_int (
        .clk      (clk),
        .rst_n    (rst_n),
        .raster   (raster),
        .hint_beg (params.hint_beg),
        .vint_beg (params.vint_beg),
        .int_n    (int_n)
    );

endmodule

`default_nettype wire

/* rtl/video_int_gen.sv */
// horizontal position is hint_beg * 2, so odd columns and values past the line end never fire
`timescale 1ns/100ps
`default_nettype none

module video_int_gen
    import video_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  raster_pos_t raster,
    input  logic [7:0]  hint_beg,
    input  logic [8:0]  vint_beg,
    output logic        int_n
);

    logic [INT_CNT_W-1:0] len_cnt;
    logic                 hit;

    assign hit = (raster.vcount == vint_beg) && (raster.hcount == {hint_beg, 1'b0});

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            len_cnt <= '0;
        else if (hit)
            len_cnt <= INT_CNT_W'(INT_LEN);
        else if (len_cnt != '0)
            len_cnt <= len_cnt - 1'b1;
    end

    // low for INT_LEN clocks after the match
    assign int_n = (len_cnt == '0);

endmodule

`default_nettype wire

/* rtl/video_port_decode.sv */
// full 8-bit port compare, legacy ports are not partially decoded; write strobes are combinational
`timescale 1ns/100ps
`default_nettype none

module video_port_decode
    import video_bus_pkg::*;
(
    input  cpu_wr_t    cpu,
    output vport_wr_t  strobes,
    output logic [7:0] data
);

    always_comb
    begin
        strobes = '0;
        if (cpu.wr)
        begin
            if (cpu.legacy)
            begin
                case (cpu.addr)
                    PORT_ZBORDER: strobes.zborder = 1'b1;
                    PORT_ZVPAGE:  strobes.zvpage  = 1'b1;
                    default:      strobes         = '0;
                endcase
            end
            else
            begin
                case (cpu.addr)
                    PORT_VCONF:     strobes.vconf     = 1'b1;
                    PORT_VPAGE:     strobes.vpage     = 1'b1;
                    PORT_GX_OFFSL:  strobes.gx_offsl  = 1'b1;
                    PORT_GX_OFFSH:  strobes.gx_offsh  = 1'b1;
                    PORT_GY_OFFSL:  strobes.gy_offsl  = 1'b1;
                    PORT_GY_OFFSH:  strobes.gy_offsh  = 1'b1;
                    PORT_TSCONF:    strobes.tsconf    = 1'b1;
                    PORT_PALSEL:    strobes.palsel    = 1'b1;
                    PORT_BORDER:    strobes.border    = 1'b1;
                    PORT_TMPAGE:    strobes.tmpage    = 1'b1;
                    PORT_T0GPAGE:   strobes.t0gpage   = 1'b1;
                    PORT_T1GPAGE:   strobes.t1gpage   = 1'b1;
                    PORT_SGPAGE:    strobes.sgpage    = 1'b1;
                    PORT_HINT_BEG:  strobes.hint_beg  = 1'b1;
                    PORT_VINT_BEGL: strobes.vint_begl = 1'b1;
                    PORT_VINT_BEGH: strobes.vint_begh = 1'b1;
                    PORT_T0X_OFFSL: strobes.t0x_offsl = 1'b1;
                    PORT_T0X_OFFSH: strobes.t0x_offsh = 1'b1;
                    PORT_T0Y_OFFSL: strobes.t0y_offsl = 1'b1;
                    PORT_T0Y_OFFSH: strobes.t0y_offsh = 1'b1;
                    PORT_T1X_OFFSL: strobes.t1x_offsl = 1'b1;
                    PORT_T1X_OFFSH: strobes.t1x_offsh = 1'b1;
                    PORT_T1Y_OFFSL: strobes.t1y_offsl = 1'b1;
                    PORT_T1Y_OFFSH: strobes.t1y_offsh = 1'b1;
                    // unmapped ports are ignored
                    default:        strobes           = '0;
                endcase
            end
        end
    end

    // the register file only needs the payload
    assign data = cpu.data;

endmodule

`default_nettype wire

/* rtl/video_ports.sv */
// staged fields change only at line start; a zvpage write wins over a line start in the same cycle
`timescale 1ns/100ps
`default_nettype none

module video_ports
    import video_bus_pkg::*;
    import video_cfg_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  vport_wr_t     strobes,
    input  logic [7:0]    data,
    input  logic          line_start,
    input  logic          frame_start,
    output video_params_t params
);

    // shadow copies of the line-staged fields
    logic [7:0] vpage_s;
    logic [7:0] vconf_s;
    logic [7:0] palsel_s;
    logic [7:0] t0gpage_s;
    logic [7:0] t1gpage_s;
    logic [8:0] gx_offs_s;
    logic [8:0] t0x_offs_s;
    logic [8:0] t1x_offs_s;

    logic [3:0] vint_step;
    logic [8:0] vint_sum;
    logic [8:0] vint_next;
    logic [7:0] zvpage_code;

    assign zvpage_code = ZVPAGE_FMT | {6'b000000, data[3], 1'b0};

    // next interrupt line, folded back once it passes line 319
    always_comb
    begin
        vint_sum  = params.vint_beg + 9'(vint_step);
        vint_next = vint_sum;
        if (vint_sum[8:6] == VINT_WRAP_HI)
            vint_next[8:6] = 3'b000;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vpage_s    <= VPAGE_RST;
            vconf_s    <= VCONF_RST;
            palsel_s   <= PALSEL_RST;
            t0gpage_s  <= '0;
            t1gpage_s  <= '0;
            gx_offs_s  <= '0;
            t0x_offs_s <= '0;
            t1x_offs_s <= '0;
        end
        else
        begin
            // legacy page also lands in the shadow so the next line keeps it
            if (strobes.zvpage)    vpage_s         <= zvpage_code;
            if (strobes.vpage)     vpage_s         <= data;
            if (strobes.vconf)     vconf_s         <= data;
            if (strobes.palsel)    palsel_s        <= data;
            if (strobes.t0gpage)   t0gpage_s       <= data;
            if (strobes.t1gpage)   t1gpage_s       <= data;
            if (strobes.gx_offsl)  gx_offs_s[7:0]  <= data;
            if (strobes.gx_offsh)  gx_offs_s[8]    <= data[0];
            if (strobes.t0x_offsl) t0x_offs_s[7:0] <= data;
            if (strobes.t0x_offsh) t0x_offs_s[8]   <= data[0];
            if (strobes.t1x_offsl) t1x_offs_s[7:0] <= data;
            if (strobes.t1x_offsh) t1x_offs_s[8]   <= data[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            params    <= PARAMS_RST;
            vint_step <= '0;
        end
        else
        begin
            // fields that take effect right away
            if (strobes.zborder)   params.border        <= {ZBORDER_HI, data[2:0]};
            if (strobes.border)    params.border        <= data;
            if (strobes.gy_offsl)  params.gy_offs[7:0]  <= data;
            if (strobes.gy_offsh)  params.gy_offs[8]    <= data[0];
            if (strobes.t0y_offsl) params.t0y_offs[7:0] <= data;
            if (strobes.t0y_offsh) params.t0y_offs[8]   <= data[0];
            if (strobes.t1y_offsl) params.t1y_offs[7:0] <= data;
            if (strobes.t1y_offsh) params.t1y_offs[8]   <= data[0];
            if (strobes.tsconf)    params.tsconf        <= data;
            if (strobes.tmpage)    params.tmpage        <= data;
            if (strobes.sgpage)    params.sgpage        <= data;
            if (strobes.hint_beg)  params.hint_beg      <= data;

            // interrupt line: cpu writes beat the per-frame step
            if (strobes.vint_begl)
                params.vint_beg[7:0] <= data;
            else if (strobes.vint_begh)
            begin
                params.vint_beg[8] <= data[0];
                vint_step          <= data[7:4];
            end
            else if (frame_start)
                params.vint_beg <= vint_next;

            if (strobes.zvpage)
                params.vpage <= zvpage_code;
            else if (line_start)
                params.vpage <= vpage_s;

            // publish the staged fields between scanlines
            if (line_start)
            begin
                params.vconf    <= vconf_s;
                params.palsel   <= palsel_s;
                params.t0gpage  <= t0gpage_s;
                params.t1gpage  <= t1gpage_s;
                params.gx_offs  <= gx_offs_s;
                params.t0x_offs <= t0x_offs_s;
                params.t1x_offs <= t1x_offs_s;
            end
        end
    end

endmodule

`default_nettype wire
